// File: project.f
hdl/xbar_pkg.sv
hdl/compare_switch.sv
hdl/batcher_xbar.sv
hdl/frame_regs.sv
hdl/sort_ctrl_fsm.sv
hdl/stage_timer.sv
hdl/sort_engine_top.sv
dv/tb_clock_gen.sv
dv/sort_engine_chk.sv
dv/sort_engine_tb.sv

// File: dv/sort_engine_tb.sv
// Sorting crossbar testbench
// Loads key frames from a table over AXI4-Lite, starts each sort and
// compares the result buffer with a software model. Also covers the
// reset state, status flags, unmapped accesses and response back-pressure

`timescale 1ns/1ns

module sort_engine_tb;

    localparam int num_rows     = 8;
    localparam int reset_cycles = 10;
    localparam int cycle_limit  = num_rows * 200 + reset_cycles;
    localparam int poll_limit   = 20;

    logic                xif;
    logic                reset;
    xbar_pkg::axil_req_t axil_req;
    xbar_pkg::axil_rsp_t axil_rsp;

    xbar_pkg::key_t table_keys [num_rows][xbar_pkg::num_ports];
    bit             table_mid_writes [num_rows];  // Write keys and a second start mid-sort
    xbar_pkg::key_t launch_keys [xbar_pkg::num_ports];
    xbar_pkg::key_t expect_keys [xbar_pkg::num_ports];
    int             value_errors = 0;
    int             other_errors = 0;
    int             cycle_count = 0;

    tb_clock_gen u_clk (
        .xif   (xif),
        .reset (reset)
    );

    sort_engine_top dut0 (
        .xif      (xif),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    bind frame_regs sort_engine_chk u_chk (
        .xif      (xif),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .busy     (busy),
        .done     (done)
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    function automatic xbar_pkg::axil_addr_t slot_addr(input xbar_pkg::axil_addr_t base,
                                                       input int slot);
        return base + xbar_pkg::axil_addr_t'(4 * slot);
    endfunction

    task automatic axil_write(input xbar_pkg::axil_addr_t addr, input xbar_pkg::axil_data_t data,
                              output xbar_pkg::axil_resp_t resp);
        int unsigned delay;
        delay = $urandom_range(3, 0);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        do begin
            @(negedge xif);
        end while (!axil_rsp.awready);
        check_value("wready", 32'd1, axil_rsp.wready);  // AW and W must be taken together
        @(negedge xif);  // Transfer happened on the rising edge just passed
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        repeat (delay) @(negedge xif);
        if (!axil_rsp.bvalid) begin
            $display("Write to %h got no write response", addr);
            other_errors++;
        end
        resp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge xif);
        axil_req.bready = 1'b0;
        if (axil_rsp.bvalid) begin
            $display("Write to %h left its response valid after it was taken", addr);
            other_errors++;
        end
    endtask

    task automatic axil_read(input xbar_pkg::axil_addr_t addr, output xbar_pkg::axil_data_t data,
                             output xbar_pkg::axil_resp_t resp);
        int unsigned delay;
        delay = $urandom_range(3, 0);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        do begin
            @(negedge xif);
        end while (!axil_rsp.arready);
        @(negedge xif);
        axil_req.arvalid = 1'b0;
        repeat (delay) @(negedge xif);
        if (!axil_rsp.rvalid) begin
            $display("Read from %h got no read response", addr);
            other_errors++;
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge xif);
        axil_req.rready = 1'b0;
        if (axil_rsp.rvalid) begin
            $display("Read from %h left its response valid after it was taken", addr);
            other_errors++;
        end
    endtask

    // Reference model, an insertion sort of the keys present at launch
    task automatic sort_model();
        xbar_pkg::key_t k;
        int j;
        for (int i = 0; i < xbar_pkg::num_ports; i++) begin
            k = launch_keys[i];
            j = i;
            while (j > 0 && expect_keys[j-1] > k) begin
                expect_keys[j] = expect_keys[j-1];
                j--;
            end
            expect_keys[j] = k;
        end
    endtask

    task automatic load_table();
        table_keys[0] = '{16'h0010, 16'h0020, 16'h0030, 16'h0040,
                          16'h0050, 16'h0060, 16'h0070, 16'h0080};
        table_keys[1] = '{16'h8000, 16'h7000, 16'h6000, 16'h5000,
                          16'h4000, 16'h3000, 16'h2000, 16'h1000};
        table_keys[2] = '{default: 16'h5a5a};
        table_keys[3] = '{16'h0003, 16'h0001, 16'h0003, 16'h0002,
                          16'h0001, 16'h0003, 16'h0002, 16'h0001};
        table_keys[4] = '{16'hffff, 16'h0000, 16'hffff, 16'h0000,
                          16'h1234, 16'hffff, 16'h0000, 16'h8000};
        for (int r = 5; r < num_rows; r++) begin
            for (int i = 0; i < xbar_pkg::num_ports; i++) begin
                table_keys[r][i] = xbar_pkg::key_t'($urandom());
            end
        end
        table_mid_writes = '{0, 1, 0, 1, 0, 1, 0, 1};
    endtask

    task automatic report_counts();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, dut0.u_regs.u_chk.assert_errors);
    endtask

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------
    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge xif);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles", cycle_limit);
        other_errors++;
        report_counts();
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main
        xbar_pkg::axil_resp_t       resp;
        xbar_pkg::axil_data_t       data;
        xbar_pkg::key_t             key;
        xbar_pkg::key_t             prev_key;
        xbar_pkg::tag_t             tag;
        logic [xbar_pkg::num_ports-1:0] tags_seen;
        bit                         got_done;

        axil_req = '0;
        void'($urandom(32'hb090_0cff));
        load_table();
        wait (reset == 1'b0);
        @(negedge xif);

        // Reset state
        axil_read(xbar_pkg::status_addr, data, resp);
        check_value("status", 32'd0, data);
        check_value("status rresp", xbar_pkg::resp_okay, resp);
        for (int i = 0; i < xbar_pkg::num_ports; i++) begin
            axil_read(slot_addr(xbar_pkg::result_base, i), data, resp);
            check_value($sformatf("result[%0d]", i), 32'd0, data);
            check_value($sformatf("result[%0d] rresp", i), xbar_pkg::resp_okay, resp);
        end

        // Unmapped accesses, neither write may touch a key or start a sort
        axil_write(8'h20, 32'hffff_ffff, resp);
        check_value("bresp at 0x20", xbar_pkg::resp_slverr, resp);
        axil_write(8'h88, 32'h0000_0001, resp);
        check_value("bresp at 0x88", xbar_pkg::resp_slverr, resp);
        axil_read(8'h60, data, resp);
        check_value("rdata at 0x60", 32'd0, data);
        check_value("rresp at 0x60", xbar_pkg::resp_slverr, resp);
        for (int i = 0; i < xbar_pkg::num_ports; i++) begin
            axil_read(slot_addr(xbar_pkg::key_base, i), data, resp);
            check_value($sformatf("key[%0d]", i), 32'd0, data);
        end
        axil_read(xbar_pkg::status_addr, data, resp);
        check_value("status after unmapped writes", 32'd0, data);

        for (int r = 0; r < num_rows; r++) begin
            for (int i = 0; i < xbar_pkg::num_ports; i++) begin
                launch_keys[i] = table_keys[r][i];
                axil_write(slot_addr(xbar_pkg::key_base, i), 32'(launch_keys[i]), resp);
                check_value($sformatf("row %0d key[%0d] bresp", r, i), xbar_pkg::resp_okay, resp);
            end
            sort_model();
            axil_write(xbar_pkg::ctrl_addr, 32'd1, resp);
            check_value("start bresp", xbar_pkg::resp_okay, resp);
            if (table_mid_writes[r]) begin
                // The second start arrives while the first sort is busy
                axil_write(xbar_pkg::ctrl_addr, 32'd1, resp);
                axil_write(slot_addr(xbar_pkg::key_base, 0), 32'(~launch_keys[0]), resp);
                axil_write(slot_addr(xbar_pkg::key_base, 7), 32'(~launch_keys[7]), resp);
            end else begin
                axil_read(xbar_pkg::status_addr, data, resp);
                check_value($sformatf("row %0d status.done after start", r), 32'd0, data[1]);
            end

            got_done = 1'b0;
            for (int p = 0; p < poll_limit && !got_done; p++) begin
                axil_read(xbar_pkg::status_addr, data, resp);
                got_done = data[1];
            end
            if (!got_done) begin
                $display("Row %0d: gave up polling status, done was never set", r);
                other_errors++;
            end else begin
                check_value($sformatf("row %0d status.busy with done", r), 32'd0, data[0]);
            end

            tags_seen = '0;
            prev_key  = '0;
            for (int i = 0; i < xbar_pkg::num_ports; i++) begin
                axil_read(slot_addr(xbar_pkg::result_base, i), data, resp);
                key = data[15:0];
                tag = data[18:16];
                check_value($sformatf("row %0d result[%0d] rresp", r, i), xbar_pkg::resp_okay, resp);
                check_value($sformatf("row %0d result[%0d] key", r, i), expect_keys[i], key);
                check_value($sformatf("row %0d result[%0d] upper bits", r, i), 32'd0, data[31:19]);
                if (i > 0 && key < prev_key) begin
                    $display("[FAIL] %0t row %0d result[%0d] expected >= %h actual %h",
                             $time, r, i, prev_key, key);
                    value_errors++;
                end
                check_value($sformatf("row %0d key of tag %0d", r, tag), launch_keys[tag], key);
                if (tags_seen[tag]) begin
                    $display("Row %0d: tag %0d appears more than once in the result", r, tag);
                    other_errors++;
                end
                tags_seen[tag] = 1'b1;
                prev_key = key;
            end
        end

        report_counts();
        if (value_errors + other_errors + dut0.u_regs.u_chk.assert_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/sort_engine_chk.sv
// Protocol and status checker for the sorting crossbar register block
// Bound into frame_regs, it watches the AXI4-Lite response channels
// and the busy and done flags

`timescale 1ns/1ns

module sort_engine_chk (
    input logic                xif,
    input logic                reset,
    input xbar_pkg::axil_req_t axil_req,
    input xbar_pkg::axil_rsp_t axil_rsp,
    input logic                busy,
    input logic                done
);

    int assert_errors = 0;  // Read by the testbench at the end of the run

    a_bvalid_hold : assert property (@(posedge xif) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
        assert_errors++;
        $error("bvalid dropped before bready");
    end

    a_rvalid_hold : assert property (@(posedge xif) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else begin
        assert_errors++;
        $error("rvalid dropped before rready");
    end

    // Writes need both address and data present
    a_awready_valid : assert property (@(posedge xif) disable iff (reset)
        axil_rsp.awready |-> axil_req.awvalid && axil_req.wvalid)
    else begin
        assert_errors++;
        $error("awready high without awvalid and wvalid");
    end

    a_busy_done : assert property (@(posedge xif) disable iff (reset)
        !(busy && done))
    else begin
        assert_errors++;
        $error("busy and done high together");
    end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and reset generator
// 40 ns clock, reset held high for the first ten cycles

`timescale 1ns/1ns

module tb_clock_gen (
    output logic xif,
    output logic reset
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 10;

    initial begin
        xif = 1'b0;
        forever #half_period xif = ~xif;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge xif);
        @(negedge xif);  // Released on a falling edge like every other input
        reset = 1'b0;
    end

endmodule

// File: hdl/sort_engine_top.sv
// Sorting crossbar top level
// Register block, sort controller, latency timer and bitonic network.
// Software loads eight keys over AXI4-Lite, starts a sort and reads
// back the keys in ascending order with their source slot tags

`timescale 1ns/1ns

module sort_engine_top (
    input  logic                xif,
    input  logic                reset,
    input  xbar_pkg::axil_req_t axil_req,
    output xbar_pkg::axil_rsp_t axil_rsp
);

    xbar_pkg::frame_t in_frame;
    xbar_pkg::frame_t sorted;
    logic             start_req;
    logic             timer_load;
    logic             expired;
    logic             capture;
    logic             busy;
    logic             done;

    frame_regs u_regs (
        .xif       (xif),
        .reset     (reset),
        .axil_req  (axil_req),
        .capture   (capture),
        .busy      (busy),
        .done      (done),
        .sorted    (sorted),
        .axil_rsp  (axil_rsp),
        .in_frame  (in_frame),
        .start_req (start_req)
    );

    sort_ctrl_fsm u_ctrl (
        .xif        (xif),
        .reset      (reset),
        .start_req  (start_req),
        .expired    (expired),
        .timer_load (timer_load),
        .capture    (capture),
        .busy       (busy),
        .done       (done)
    );

    stage_timer u_timer (
        .xif     (xif),
        .reset   (reset),
        .load    (timer_load),
        .expired (expired)
    );

    // Free running, the controller only decides when to capture
    batcher_xbar u_xbar (
        .xif       (xif),
        .reset     (reset),
        .in_frame  (in_frame),
        .out_frame (sorted)
    );

endmodule

// File: hdl/stage_timer.sv
// Pipeline latency timer
// Loads num_stages minus 1, counts down to zero and holds there.
// expired stays high while the count is zero

`timescale 1ns/1ns

module stage_timer (
    input  logic xif,
    input  logic reset,
    input  logic load,
    output logic expired
);

    xbar_pkg::count_t count;

    always_ff @(posedge xif) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= xbar_pkg::count_t'(xbar_pkg::num_stages - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired = count == '0;

endmodule

// File: hdl/sort_ctrl_fsm.sv
// Sort controller
// Launches a wavefront into the network on start, waits for the
// stage timer and loads the result buffer on the exact edge the
// launched frame reaches the network output

`timescale 1ns/1ns

module sort_ctrl_fsm (
    input  logic xif,
    input  logic reset,
    input  logic start_req,
    input  logic expired,
    output logic timer_load,
    output logic capture,
    output logic busy,
    output logic done
);

    xbar_pkg::sort_state_t state;

    // The launch edge is the one leaving idle
    assign timer_load = (state == xbar_pkg::idle) && start_req;

    // Fires on the edge that leaves run, num_stages edges after launch
    assign capture = (state == xbar_pkg::run) && expired;

    always_ff @(posedge xif) begin
        if (reset) begin
            state <= xbar_pkg::idle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            case (state)
                xbar_pkg::idle: begin
                    if (start_req) begin
                        state <= xbar_pkg::run;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                xbar_pkg::run: begin
                    if (expired) state <= xbar_pkg::capture;
                end
                xbar_pkg::capture: begin
                    state <= xbar_pkg::idle;
                    busy  <= 1'b0;  // Cleared on the same edge done rises
                    done  <= 1'b1;
                end
                default: state <= xbar_pkg::idle;
            endcase
        end
    end

endmodule

// File: hdl/frame_regs.sv
// AXI4-Lite register block of the sorting crossbar
// Holds the eight input keys, the result buffer and the status bits.
// Writes wait for both AW and W, reads take one cycle, and no new
// request is taken while a response is still pending

`timescale 1ns/1ns

module frame_regs (
    input  logic                xif,
    input  logic                reset,
    input  xbar_pkg::axil_req_t axil_req,
    input  logic                capture,
    input  logic                busy,
    input  logic                done,
    input  xbar_pkg::frame_t    sorted,
    output xbar_pkg::axil_rsp_t axil_rsp,
    output xbar_pkg::frame_t    in_frame,
    output logic                start_req
);

    xbar_pkg::key_t       keys_q [xbar_pkg::num_ports];
    xbar_pkg::frame_t     result_q;
    logic                 awready_q, bvalid_q, arready_q, rvalid_q;
    xbar_pkg::axil_resp_t bresp_q, rresp_q;
    xbar_pkg::axil_data_t rdata_q, rd_word;
    logic                 wr_fire, rd_fire;
    logic                 wr_key, wr_ctrl, wr_mapped;
    logic                 rd_key, rd_result, rd_status, rd_mapped;
    xbar_pkg::tag_t       wr_slot, rd_slot;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------
    assign wr_slot   = axil_req.awaddr[4:2];
    assign wr_key    = (axil_req.awaddr & xbar_pkg::slot_mask) == xbar_pkg::key_base;
    assign wr_ctrl   = axil_req.awaddr == xbar_pkg::ctrl_addr;
    assign wr_mapped = wr_key || wr_ctrl || axil_req.awaddr == xbar_pkg::status_addr ||
                       (axil_req.awaddr & xbar_pkg::slot_mask) == xbar_pkg::result_base;

    assign rd_slot   = axil_req.araddr[4:2];
    assign rd_key    = (axil_req.araddr & xbar_pkg::slot_mask) == xbar_pkg::key_base;
    assign rd_result = (axil_req.araddr & xbar_pkg::slot_mask) == xbar_pkg::result_base;
    assign rd_status = axil_req.araddr == xbar_pkg::status_addr;
    assign rd_mapped = rd_key || rd_result || rd_status ||
                       axil_req.araddr == xbar_pkg::ctrl_addr;

    assign wr_fire = awready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = arready_q && axil_req.arvalid;

    always_comb begin
        rd_word = '0;  // Unmapped and control reads return zero
        if (rd_key) begin
            rd_word = xbar_pkg::axil_data_t'(keys_q[rd_slot]);
        end else if (rd_result) begin
            rd_word = xbar_pkg::axil_data_t'(result_q[rd_slot]);
        end else if (rd_status) begin
            rd_word = {30'd0, done, busy};
        end
    end

    // ----------------------------------------------------------
    // Write channel and key storage
    // ----------------------------------------------------------
    always_ff @(posedge xif) begin
        if (reset) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            start_req <= 1'b0;
            for (int i = 0; i < xbar_pkg::num_ports; i++) begin
                keys_q[i] <= '0;
            end
        end else begin
            awready_q <= axil_req.awvalid && axil_req.wvalid && !awready_q && !bvalid_q;
            start_req <= 1'b0;
            if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                if (wr_key) begin
                    if (axil_req.wstrb[0]) keys_q[wr_slot][7:0]  <= axil_req.wdata[7:0];
                    if (axil_req.wstrb[1]) keys_q[wr_slot][15:8] <= axil_req.wdata[15:8];
                end else if (wr_ctrl) begin
                    start_req <= axil_req.wdata[0];
                end
            end
        end
    end

    always_ff @(posedge xif) begin
        if (wr_fire) begin
            bresp_q <= wr_mapped ? xbar_pkg::resp_okay : xbar_pkg::resp_slverr;
        end
    end

    // ----------------------------------------------------------
    // Read channel and result buffer
    // ----------------------------------------------------------
    always_ff @(posedge xif) begin
        if (reset) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            result_q  <= '0;  // Results read back as zero until the first sort
        end else begin
            arready_q <= axil_req.arvalid && !arready_q && !rvalid_q;
            if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end
            if (capture) begin
                result_q <= sorted;
            end
        end
    end

    always_ff @(posedge xif) begin
        if (rd_fire) begin
            rdata_q <= rd_word;
            rresp_q <= rd_mapped ? xbar_pkg::resp_okay : xbar_pkg::resp_slverr;
        end
    end

    always_comb begin
        axil_rsp.awready = awready_q;
        axil_rsp.wready  = awready_q;  // AW and W always handshake together
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = arready_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

    // Each entry is tagged with its own slot number
    always_comb begin
        for (int i = 0; i < xbar_pkg::num_ports; i++) begin
            in_frame[i].key = keys_q[i];
            in_frame[i].tag = xbar_pkg::tag_t'(i);
        end
    end

endmodule

// File: hdl/batcher_xbar.sv
// Pipelined bitonic sorting network
// One register rank per network stage, so a frame presented at the
// input appears sorted in ascending key order num_stages edges later.
// A new wavefront may enter on every clock

`timescale 1ns/1ns

module batcher_xbar (
    input  logic             xif,
    input  logic             reset,
    input  xbar_pkg::frame_t in_frame,
    output xbar_pkg::frame_t out_frame
);

    xbar_pkg::frame_t stage_q [1:xbar_pkg::num_stages];
    xbar_pkg::frame_t stage_d [1:xbar_pkg::num_stages];

    // ----------------------------------------------------------
    // Pipeline ranks
    // ----------------------------------------------------------
    always_ff @(posedge xif) begin
        if (reset) begin
            for (int s = 1; s <= xbar_pkg::num_stages; s++) begin
                stage_q[s] <= '0;
            end
        end else begin
            for (int s = 1; s <= xbar_pkg::num_stages; s++) begin
                stage_q[s] <= stage_d[s];
            end
        end
    end

    // ----------------------------------------------------------
    // Network nodes
    // ----------------------------------------------------------
    for (genvar p = 1; p <= xbar_pkg::tag_width; p++) begin : g_merge
        localparam int k = 1 << p;  // Size of the bitonic block being merged
        for (genvar q = p; q >= 1; q--) begin : g_step
            localparam int j = 1 << (q - 1);  // Pair distance
            localparam int stage = (p - 1) * p / 2 + (p - q + 1);

            xbar_pkg::frame_t src;

            if (stage == 1) begin : g_first
                assign src = in_frame;
            end else begin : g_later
                assign src = stage_q[stage-1];
            end

            for (genvar i = 0; i < xbar_pkg::num_ports; i++) begin : g_node
                localparam int ixj = i ^ j;

                if (ixj > i) begin : g_pair
                    xbar_pkg::entry_t ord_lo;
                    xbar_pkg::entry_t ord_hi;

                    // Smaller key to the lower index
                    compare_switch u_order (
                        .a    (src[i]),
                        .b    (src[ixj]),
                        .swap (src[ixj].key < src[i].key),
                        .lo   (ord_lo),
                        .hi   (ord_hi)
                    );

                    // Reverse inside descending blocks
                    compare_switch u_dir (
                        .a    (ord_lo),
                        .b    (ord_hi),
                        .swap ((i & k) != 0),
                        .lo   (stage_d[stage][i]),
                        .hi   (stage_d[stage][ixj])
                    );
                end
            end
        end
    end

    assign out_frame = stage_q[xbar_pkg::num_stages];

endmodule

// File: hdl/compare_switch.sv
// Two-entry exchange element
// Passes a and b straight through, or crosses them when swap is set.
// Key and tag move together as one entry

`timescale 1ns/1ns

module compare_switch (
    input  xbar_pkg::entry_t a,
    input  xbar_pkg::entry_t b,
    input  logic             swap,
    output xbar_pkg::entry_t lo,
    output xbar_pkg::entry_t hi
);

    always_comb begin
        if (swap) begin
            lo = b;
            hi = a;
        end else begin
            lo = a;
            hi = b;
        end
    end

endmodule

// File: hdl/xbar_pkg.sv
// Sorting crossbar shared definitions
// Frame geometry, the AXI4-Lite bus bundles, the register map
// and the controller state encoding

package xbar_pkg;

    // ----------------------------------------------------------
    // Frame geometry
    // ----------------------------------------------------------
    localparam int num_ports  = 8;
    localparam int tag_width  = 3;  // log2 of num_ports
    localparam int key_width  = 16;
    localparam int num_stages = tag_width * (tag_width + 1) / 2;

    typedef logic [key_width-1:0]              key_t;
    typedef logic [tag_width-1:0]              tag_t;
    typedef logic [$clog2(num_stages)-1:0]     count_t;

    typedef struct packed {
        tag_t tag;  // Slot the key was written to
        key_t key;
    } entry_t;

    typedef entry_t [num_ports-1:0] frame_t;

    // ----------------------------------------------------------
    // AXI4-Lite
    // ----------------------------------------------------------
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    // Register map, byte offsets
    localparam axil_addr_t key_base    = 8'h00;
    localparam axil_addr_t result_base = 8'h40;
    localparam axil_addr_t ctrl_addr   = 8'h80;
    localparam axil_addr_t status_addr = 8'h84;
    localparam axil_addr_t slot_mask   = 8'he3;  // Keeps region and alignment bits

    typedef enum logic [1:0] {
        idle,
        run,
        capture
    } sort_state_t;

endpackage
